/* flist.f */
src/xbus_pkg.sv
src/xbus_if.sv
src/busint.sv
src/xbus_ram.sv
src/xbus_disk.sv
src/xbus_io.sv
src/caddr_xbus.sv
bench/tb_clock.sv
bench/tb_caddr_xbus.sv

/* Makefile */
# Verilator build and run of the xbus testbench

TOP = tb_caddr_xbus

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -j 0 -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* bench/tb_caddr_xbus.sv */
//////////////////////////////
// testbench for the xbus, table of accesses run through req/ack/load
// reference model predicts every read, dram not reset so reads follow writes
// dma reads back only after status shows done
// timer is stopped before pending is read or cleared
//////////////////////////////
`timescale 1ns/1ps

module tb_caddr_xbus import xbus_pkg::*;
();

   localparam int RAM_AW       = 10;
   localparam int SECTOR_WORDS = 16;

   typedef enum logic [1:0]
   {
      op_write,
      op_read,
      op_wait_irq,
      op_poll
   } op_t;

   typedef struct packed
   {
      op_t    op;
      xaddr_t addr;
      xword_t data;                      // write data, or mask for a poll
      logic   chk_irq;
      logic   exp_irq;
   } entry_t;

   logic   mclk;
   logic   reset;
   xaddr_t addr;
   xword_t busin;
   xword_t busout;
   logic   req;
   logic   write;
   logic   ack;
   logic   load;
   logic   interrupt;

   entry_t      stim [$];
   logic [31:0] lfsr_state = 32'h65b54e5c;
   int          cycle_count = 0;
   int          cycle_limit = 2000;

   // reference model state
   xword_t model_mem [2**RAM_AW];
   xword_t model_sector [SECTOR_WORDS];
   int     model_fill = 0;
   xaddr_t model_target = '0;
   logic   model_done = 1'b0;
   xword_t model_scratch = '0;
   xword_t model_interval = '0;
   logic   model_pending = 1'b0;

   tb_clock u_tb_clock
   (
      .mclk  (mclk),
      .reset (reset)
   );

   caddr_xbus #(.RAM_AW(RAM_AW), .SECTOR_WORDS(SECTOR_WORDS)) u_caddr_xbus
   (
      .mclk      (mclk),
      .reset     (reset),
      .addr      (addr),
      .busin     (busin),
      .busout    (busout),
      .req       (req),
      .write     (write),
      .ack       (ack),
      .load      (load),
      .interrupt (interrupt)
   );

   always @(posedge mclk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("timeout after %0d cycles, the bus never finished", cycle_count);
         $display("CHECKS FAILED");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   // galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h80200003;
      else
         return s >> 1;
   endfunction

   task automatic rand_word(output xword_t w);
      int i;
      w = '0;
      for (i = 0; i < 32; i++)
      begin
         w = {w[30:0], lfsr_state[0]};   // one step per bit
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   task automatic check_word(input string name, input xword_t got, input xword_t exp);
      if (got !== exp)
      begin
         $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
         $display("CHECKS FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
         $display("CHECKS FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   function automatic xword_t model_read(input xaddr_t a);
      if (a < DRAM_TOP)
         return model_mem[a[RAM_AW-1:0]];
      if (a[21:3] == DISK_BASE[21:3])
      begin
         case (a[2:0])
            3'd0:    return {30'b0, model_done, 1'b0};   // never busy when read
            3'd1:    return xword_t'(model_target);
            3'd2:    return xword_t'(model_fill);
            default: return '0;
         endcase
      end
      if (a[21:2] == IO_BASE[21:2])
      begin
         case (a[1:0])
            2'd0:    return model_scratch;
            2'd1:    return model_interval;
            2'd2:    return {31'b0, model_pending};
            default: return '0;                           // counter not modelled
         endcase
      end
      return '0;                          // nothing decodes, timed out
   endfunction

   task automatic model_write(input xaddr_t a, input xword_t d);
      xaddr_t t;
      int     i;
      if (a < DRAM_TOP)
         model_mem[a[RAM_AW-1:0]] = d;
      else if (a[21:3] == DISK_BASE[21:3])
      begin
         if (a[2:0] == 3'd1)
            model_target = d[21:0];
         else if (a[2:0] == 3'd2)
         begin
            model_sector[model_fill] = d;
            model_fill = (model_fill + 1) % SECTOR_WORDS;
         end
         else if (a[2:0] == 3'd0 && d == 32'd0)
            model_done = 1'b0;
         else if (a[2:0] == 3'd0 && d <= xword_t'(SECTOR_WORDS))
         begin
            // whole transfer counted as landed, nothing reads it before done
            for (i = 0; i < int'(d); i++)
            begin
               t = model_target + xaddr_t'(i);
               model_mem[t[RAM_AW-1:0]] = model_sector[i];
            end
            model_done = 1'b1;
            model_fill = 0;
         end
      end
      else if (a[21:2] == IO_BASE[21:2])
      begin
         if (a[1:0] == 2'd0)
            model_scratch = d;
         else if (a[1:0] == 2'd1)
            model_interval = d;
         else if (a[1:0] == 2'd2)
            model_pending = 1'b0;
      end
   endtask

   task automatic add_entry(input op_t op, input xaddr_t a, input xword_t d,
                            input logic chk, input logic irq);
      entry_t e;
      e.op      = op;
      e.addr    = a;
      e.data    = d;
      e.chk_irq = chk;
      e.exp_irq = irq;
      stim.push_back(e);
   endtask

   task automatic write_rand(input xaddr_t a);
      xword_t w;
      rand_word(w);
      add_entry(op_write, a, w, 1'b0, 1'b0);
   endtask

   task automatic build_table();
      int i;
      write_rand(22'd0);
      write_rand(22'd5);
      write_rand(22'o400);
      write_rand(22'd511);
      write_rand(22'd1023);
      write_rand(22'd1031);                // lands on word 7
      add_entry(op_read, 22'd0, 32'd0, 1'b1, 1'b0);
      add_entry(op_read, 22'd5, 32'd0, 1'b0, 1'b0);
      add_entry(op_read, 22'o400, 32'd0, 1'b0, 1'b0);
      add_entry(op_read, 22'd511, 32'd0, 1'b0, 1'b0);
      add_entry(op_read, 22'd7, 32'd0, 1'b0, 1'b0);
      write_rand(22'o16777777);            // top of dram, word 1023
      add_entry(op_read, 22'd1023, 32'd0, 1'b0, 1'b0);
      add_entry(op_read, 22'd2047, 32'd0, 1'b0, 1'b0);
      // old unibus range, nothing answers
      add_entry(op_read, 22'o17400100, 32'd0, 1'b1, 1'b0);
      write_rand(22'o17400100);
      add_entry(op_read, 22'o17400100, 32'd0, 1'b1, 1'b0);
      write_rand(IO_BASE);
      add_entry(op_read, IO_BASE, 32'd0, 1'b1, 1'b0);
      add_entry(op_write, IO_BASE + 22'd1, 32'd25, 1'b0, 1'b0);
      add_entry(op_wait_irq, IO_BASE, 32'd0, 1'b1, 1'b1);
      add_entry(op_write, IO_BASE + 22'd1, 32'd0, 1'b1, 1'b1);   // timer off, still pending
      add_entry(op_read, IO_BASE + 22'd1, 32'd0, 1'b0, 1'b0);
      add_entry(op_read, IO_BASE + 22'd2, 32'd0, 1'b1, 1'b1);
      add_entry(op_write, IO_BASE + 22'd2, 32'd0, 1'b1, 1'b0);
      add_entry(op_read, IO_BASE + 22'd2, 32'd0, 1'b1, 1'b0);
      // dma with the bus otherwise idle
      for (i = 0; i < 12; i++)
         write_rand(DISK_BASE + 22'd2);
      add_entry(op_write, DISK_BASE + 22'd1, 32'o100, 1'b0, 1'b0);
      add_entry(op_read, DISK_BASE + 22'd1, 32'd0, 1'b0, 1'b0);
      add_entry(op_write, DISK_BASE, 32'd12, 1'b0, 1'b0);
      add_entry(op_poll, DISK_BASE, 32'd2, 1'b1, 1'b1);
      for (i = 0; i < 12; i++)
         add_entry(op_read, 22'o100 + xaddr_t'(i), 32'd0, 1'b0, 1'b0);
      add_entry(op_write, DISK_BASE, 32'd0, 1'b1, 1'b0);
      add_entry(op_read, DISK_BASE, 32'd0, 1'b0, 1'b0);
      // full sector, processor reads dram while the disk is busy
      for (i = 0; i < SECTOR_WORDS; i++)
         write_rand(DISK_BASE + 22'd2);
      add_entry(op_write, DISK_BASE + 22'd1, 32'o600, 1'b0, 1'b0);
      add_entry(op_write, DISK_BASE, xword_t'(SECTOR_WORDS), 1'b0, 1'b0);
      add_entry(op_read, 22'd0, 32'd0, 1'b0, 1'b0);
      add_entry(op_read, 22'd5, 32'd0, 1'b0, 1'b0);
      add_entry(op_read, 22'o400, 32'd0, 1'b0, 1'b0);
      add_entry(op_read, 22'd511, 32'd0, 1'b0, 1'b0);
      add_entry(op_read, 22'd7, 32'd0, 1'b0, 1'b0);
      add_entry(op_read, 22'd1023, 32'd0, 1'b0, 1'b0);
      add_entry(op_poll, DISK_BASE, 32'd2, 1'b1, 1'b1);
      for (i = 0; i < SECTOR_WORDS; i++)
         add_entry(op_read, 22'o600 + xaddr_t'(i), 32'd0, 1'b0, 1'b0);
      add_entry(op_write, DISK_BASE, 32'd0, 1'b1, 1'b0);
   endtask

   // one processor access, returns read data taken while load is high
   task automatic bus_access(input logic wr, input xaddr_t a, input xword_t d,
                             output xword_t rd);
      @(posedge mclk);
      addr  <= a;
      busin <= d;
      write <= wr;
      req   <= 1'b1;
      @(negedge mclk);
      while (ack !== 1'b1)
         @(negedge mclk);
      @(negedge mclk);                    // now in bus_wait
      rd = '0;
      if (!wr)
      begin
         check_bit("load", load, 1'b1);
         rd = busout;
      end
      @(posedge mclk);
      req <= 1'b0;
      @(posedge mclk);                    // processor idle for a cycle, disk may take the bus
   endtask

   task automatic wait_interrupt();
      @(negedge mclk);
      while (interrupt !== 1'b1)
         @(negedge mclk);
   endtask

   task automatic poll_done(input xaddr_t a, input xword_t mask);
      xword_t rd;
      int     tries;
      bus_access(1'b0, a, 32'd0, rd);
      tries = 1;
      while ((rd & mask) !== mask && tries < 100)
      begin
         bus_access(1'b0, a, 32'd0, rd);
         tries++;
      end
      if ((rd & mask) !== mask)
      begin
         $display("disk status never showed done after %0d polls", tries);
         $display("CHECKS FAILED");
         $fatal(1, "polling gave up");
      end
      else
         check_word("busout", rd, model_read(a));
   endtask

   task automatic run_entry(input entry_t e);
      xword_t rd;
      case (e.op)
         op_write:
         begin
            bus_access(1'b1, e.addr, e.data, rd);
            model_write(e.addr, e.data);
         end
         op_read:
         begin
            bus_access(1'b0, e.addr, 32'd0, rd);
            check_word("busout", rd, model_read(e.addr));
         end
         op_wait_irq:
         begin
            wait_interrupt();
            model_pending = 1'b1;          // only the timer is waited on
         end
         default:
            poll_done(e.addr, e.data);
      endcase
      if (e.chk_irq)
      begin
         @(negedge mclk);
         check_bit("interrupt", interrupt, e.exp_irq);
      end
   endtask

   initial
   begin
      req   = 1'b0;
      write = 1'b0;
      addr  = '0;
      busin = '0;
      build_table();
      cycle_limit = stim.size() * 64 + 2000;
      wait (reset === 1'b0);
      @(negedge mclk);
      check_bit("ack", ack, 1'b0);
      check_bit("load", load, 1'b0);
      check_bit("interrupt", interrupt, 1'b0);
      foreach (stim[i])
         run_entry(stim[i]);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* bench/tb_clock.sv */
//////////////////////////////
// testbench clock, 4 ns period
// reset high for the first 4 rising edges
//////////////////////////////
`timescale 1ns/1ps

module tb_clock
(
   output logic mclk,
   output logic reset
);

   initial
   begin
      mclk = 1'b0;
      forever
         #2 mclk = ~mclk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (4) @(posedge mclk);
      reset <= 1'b0;                     // released on an edge like the other inputs
   end

endmodule

/* src/caddr_xbus.sv */
//////////////////////////////
// xbus top, arbiter plus dram, disk and i/o board
// processor holds req until ack, then until done with load
//////////////////////////////
`timescale 1ns/1ps

module caddr_xbus import xbus_pkg::*;
#(
   parameter int RAM_AW       = 10,
   parameter int SECTOR_WORDS = 16
)
(
   input  logic   mclk,
   input  logic   reset,
   input  xaddr_t addr,
   input  xword_t busin,
   output xword_t busout,
   input  logic   req,
   input  logic   write,
   output logic   ack,
   output logic   load,
   output logic   interrupt
);

   xbus_if ram_bus ();
   xbus_if disk_bus ();
   xbus_if io_bus ();

   logic   dma_req;
   xaddr_t dma_addr;
   xword_t dma_data;
   logic   dma_grant;
   logic   disk_irq;
   logic   io_irq;

   busint u_busint
   (
      .mclk      (mclk),
      .reset     (reset),
      .addr      (addr),
      .busin     (busin),
      .busout    (busout),
      .req       (req),
      .write     (write),
      .ack       (ack),
      .load      (load),
      .interrupt (interrupt),
      .ram       (ram_bus.master),
      .disk      (disk_bus.master),
      .io        (io_bus.master),
      .dma_req   (dma_req),
      .dma_addr  (dma_addr),
      .dma_data  (dma_data),
      .dma_grant (dma_grant),
      .disk_irq  (disk_irq),
      .io_irq    (io_irq)
   );

   xbus_ram #(.RAM_AW(RAM_AW)) u_xbus_ram
   (
      .mclk  (mclk),
      .reset (reset),
      .bus   (ram_bus.slave)
   );

   xbus_disk #(.SECTOR_WORDS(SECTOR_WORDS)) u_xbus_disk
   (
      .mclk      (mclk),
      .reset     (reset),
      .bus       (disk_bus.slave),
      .dma_req   (dma_req),
      .dma_addr  (dma_addr),
      .dma_data  (dma_data),
      .dma_grant (dma_grant),
      .irq       (disk_irq)
   );

   xbus_io u_xbus_io
   (
      .mclk  (mclk),
      .reset (reset),
      .bus   (io_bus.slave),
      .irq   (io_irq)
   );

endmodule

/* src/xbus_io.sv */
//////////////////////////////
// i/o board slave, scratch reg and interval timer
// interval 0 stops the timer
// pending stays set until written
//////////////////////////////
`timescale 1ns/1ps

module xbus_io import xbus_pkg::*;
(
   input  logic  mclk,
   input  logic  reset,
   xbus_if.slave bus,
   output logic  irq
);

   xword_t     scratch;
   xword_t     interval;
   xword_t     count;                    // down counter, reloads on expiry
   xword_t     rd_q;
   logic [1:0] reg_idx;
   logic       ack_q;
   logic       take;
   logic       pending;

   assign bus.decode = (bus.addr[21:2] == IO_BASE[21:2]);
   assign reg_idx    = bus.addr[1:0];
   assign take       = bus.req && bus.decode && !ack_q;

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         ack_q    <= 1'b0;
         interval <= '0;
         count    <= '0;
         pending  <= 1'b0;
      end
      else
      begin
         ack_q <= bus.req && bus.decode;

         if (interval != '0)
         begin
            if (count <= 32'd1)
            begin
               count   <= interval;
               pending <= 1'b1;
            end
            else
               count <= count - 32'd1;
         end

         // register writes win over the timer
         if (take && bus.write)
         begin
            if (reg_idx == 2'd1)
            begin
               interval <= bus.wdata;
               count    <= bus.wdata;
            end
            if (reg_idx == 2'd2)
               pending <= 1'b0;
         end
      end
   end

   always_ff @(posedge mclk)
   begin
      if (take && bus.write && reg_idx == 2'd0)
         scratch <= bus.wdata;
   end

   always_ff @(posedge mclk)
   begin
      if (take)
      begin
         case (reg_idx)
            2'd0:    rd_q <= scratch;
            2'd1:    rd_q <= interval;
            2'd2:    rd_q <= {31'b0, pending};
            default: rd_q <= count;
         endcase
      end
   end

   assign bus.rdata = rd_q;
   assign bus.ack   = ack_q && bus.req && bus.decode;
   assign irq       = pending;

endmodule

/* src/xbus_disk.sv */
//////////////////////////////
// disk controller, regs at DISK_BASE and dma master into dram
// SECTOR_WORDS must be a power of two, at least 2
// fill pointer wraps, start while busy is ignored
// n above SECTOR_WORDS is ignored
//////////////////////////////
`timescale 1ns/1ps

module xbus_disk import xbus_pkg::*;
#(
   parameter int SECTOR_WORDS = 16
)
(
   input  logic   mclk,
   input  logic   reset,
   xbus_if.slave  bus,
   output logic   dma_req,
   output xaddr_t dma_addr,
   output xword_t dma_data,
   input  logic   dma_grant,
   output logic   irq
);

   localparam int PTR_W = $clog2(SECTOR_WORDS);

   xword_t           sector [SECTOR_WORDS];
   xword_t           rd_q;
   xaddr_t           target;             // dram address of word 0
   logic [2:0]       reg_idx;
   logic             ack_q;
   logic             take;
   logic             start_ok;
   logic             busy;
   logic             done;
   logic [PTR_W-1:0] fill_ptr;
   logic [PTR_W:0]   xfer_len;           // words in this transfer
   logic [PTR_W:0]   dma_idx;

   assign bus.decode = (bus.addr[21:3] == DISK_BASE[21:3]);
   assign reg_idx    = bus.addr[2:0];
   assign take       = bus.req && bus.decode && !ack_q;
   assign start_ok   = (bus.wdata != '0) && (bus.wdata <= SECTOR_WORDS) && !busy;

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         ack_q    <= 1'b0;
         busy     <= 1'b0;
         done     <= 1'b0;
         fill_ptr <= '0;
         xfer_len <= '0;
         dma_idx  <= '0;
      end
      else
      begin
         ack_q <= bus.req && bus.decode;

         if (busy && dma_grant)
         begin
            dma_idx <= dma_idx + 1'b1;
            if (dma_idx + 1'b1 == xfer_len)
            begin
               busy <= 1'b0;            // last word written
               done <= 1'b1;
            end
         end

         if (take && bus.write)
         begin
            case (reg_idx)
               3'd0:
               begin
                  if (start_ok)
                  begin
                     busy     <= 1'b1;
                     done     <= 1'b0;
                     xfer_len <= bus.wdata[PTR_W:0];
                     dma_idx  <= '0;
                     fill_ptr <= '0;
                  end
                  else if (bus.wdata == '0)
                     done <= 1'b0;      // clears irq too
               end
               3'd2:
                  fill_ptr <= fill_ptr + 1'b1;
               default:
                  ;
            endcase
         end
      end
   end

   always_ff @(posedge mclk)
   begin
      if (take && bus.write)
      begin
         if (reg_idx == 3'd1)
            target <= bus.wdata[21:0];
         if (reg_idx == 3'd2)
            sector[fill_ptr] <= bus.wdata;
      end
   end

   always_ff @(posedge mclk)
   begin
      if (take)
      begin
         case (reg_idx)
            3'd0:    rd_q <= {30'b0, done, busy};
            3'd1:    rd_q <= xword_t'(target);
            3'd2:    rd_q <= xword_t'(fill_ptr);
            default: rd_q <= '0;
         endcase
      end
   end

   assign bus.rdata = rd_q;
   assign bus.ack   = ack_q && bus.req && bus.decode;

   // one word at a time, held until granted
   assign dma_req  = busy;
   assign dma_addr = target + xaddr_t'(dma_idx);
   assign dma_data = sector[dma_idx[PTR_W-1:0]];
   assign irq      = done;

endmodule

/* src/xbus_ram.sv */
//////////////////////////////
// dram slave, 2**RAM_AW words
// wraps on the low RAM_AW address bits
// ack one registered cycle after req is seen
//////////////////////////////
`timescale 1ns/1ps

module xbus_ram import xbus_pkg::*;
#(
   parameter int RAM_AW = 10
)
(
   input  logic mclk,
   input  logic reset,
   xbus_if.slave bus
);

   xword_t            mem [2**RAM_AW];
   xword_t            rd_q;
   logic [RAM_AW-1:0] word_idx;
   logic              ack_q;
   logic              take;              // first cycle of a request

   assign bus.decode = (bus.addr < DRAM_TOP);
   assign word_idx   = bus.addr[RAM_AW-1:0];   // aliases above the array
   assign take       = bus.req && bus.decode && !ack_q;

   always_ff @(posedge mclk)
   begin
      if (reset)
         ack_q <= 1'b0;
      else
         ack_q <= bus.req && bus.decode;
   end

   always_ff @(posedge mclk)
   begin
      if (take)
      begin
         if (bus.write)
            mem[word_idx] <= bus.wdata;
         rd_q <= mem[word_idx];         // old data on a write, unused
      end
   end

   assign bus.rdata = rd_q;
   assign bus.ack   = ack_q && bus.req && bus.decode;

endmodule

/* src/busint.sv */
//////////////////////////////
// bus arbiter and read mux, processor has priority over disk dma
// slaves see processor req only in bus_req and bus_wait
// undecoded reads return zero, dma target must be in dram
//////////////////////////////
`timescale 1ns/1ps

module busint import xbus_pkg::*;
(
   input  logic   mclk,
   input  logic   reset,
   input  xaddr_t addr,
   input  xword_t busin,
   output xword_t busout,
   input  logic   req,
   input  logic   write,
   output logic   ack,
   output logic   load,
   output logic   interrupt,
   xbus_if.master ram,
   xbus_if.master disk,
   xbus_if.master io,
   input  logic   dma_req,
   input  xaddr_t dma_addr,
   input  xword_t dma_data,
   output logic   dma_grant,
   input  logic   disk_irq,
   input  logic   io_irq
);

   bus_state_t state;
   bus_state_t next_state;
   logic [4:0] timeout_count;
   logic       timed_out;
   logic       slave_mode;                 // disk owns dram
   logic       proc_req;                   // req as seen by slaves
   logic       device_ack;
   logic       ram_sel;

   assign slave_mode = (state == bus_slave);
   assign proc_req   = req && (state == bus_req || state == bus_wait);

   // dram is steered to the disk while it is bus master
   assign ram.addr  = slave_mode ? dma_addr : addr;
   assign ram.wdata = slave_mode ? dma_data : busin;
   assign ram.req   = slave_mode ? dma_req : proc_req;
   assign ram.write = slave_mode ? 1'b1 : write;   // dma only writes

   assign disk.addr  = addr;
   assign disk.wdata = busin;
   assign disk.req   = proc_req;
   assign disk.write = write;

   assign io.addr  = addr;
   assign io.wdata = busin;
   assign io.req   = proc_req;
   assign io.write = write;

   assign device_ack = ram.ack | disk.ack | io.ack | timed_out;
   assign ack        = (state == bus_req) && device_ack;
   assign load       = req && !write && (state == bus_wait);
   assign dma_grant  = slave_mode && ram.ack;
   assign interrupt  = disk_irq | io_irq;

   always_comb
   begin
      next_state = state;
      unique case (state)
         bus_idle:
         begin
            if (req)
               next_state = bus_req;
            else if (dma_req)
               next_state = bus_slave;
         end
         bus_req:
         begin
            if (device_ack)
               next_state = bus_wait;
         end
         bus_wait:
         begin
            if (!req)
               next_state = bus_idle;   // processor done with the data
         end
         bus_slave:
         begin
            if (ram.ack)
               next_state = bus_idle;   // one dma word per grant
         end
         default:
            next_state = bus_idle;
      endcase
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
         state <= bus_idle;
      else
         state <= next_state;
   end

   // nobody answered, give up after a while
   always_ff @(posedge mclk)
   begin
      if (reset)
         timeout_count <= '0;
      else if (state == bus_req && !timed_out)
         timeout_count <= timeout_count + 5'd1;
      else if (state == bus_wait)
         timeout_count <= '0;
   end

   assign timed_out = (timeout_count == TIMEOUT_LIMIT);

   // read data by decode, zero when nothing decodes
   assign ram_sel = ram.decode && !slave_mode;

   always_comb
   begin
      if (!req || write)
         busout = '1;
      else if (ram_sel)
         busout = ram.rdata;
      else if (disk.decode)
         busout = disk.rdata;
      else if (io.decode)
         busout = io.rdata;
      else
         busout = '0;                   // timed out read
   end

endmodule

/* src/xbus_if.sv */
//////////////////////////////
// one arbiter to slave link, req/ack handshake
// decode is combinational from addr
// a slave acks only while req and decode are high
//////////////////////////////
`timescale 1ns/1ps

interface xbus_if import xbus_pkg::*; ();

   xaddr_t addr;
   xword_t wdata;
   xword_t rdata;
   logic   req;
   logic   write;
   logic   ack;
   logic   decode;

   modport master
   (
      output addr,
      output wdata,
      output req,
      output write,
      input  rdata,
      input  ack,
      input  decode
   );

   modport slave
   (
      input  addr,
      input  wdata,
      input  req,
      input  write,
      output rdata,
      output ack,
      output decode
   );

endinterface

/* src/xbus_pkg.sv */
//////////////////////////////
// shared types and address map for the xbus
// addresses are 22 bit word addresses, octal as in the machine docs
// tv and unibus ranges are not mapped and end by timeout
//////////////////////////////

package xbus_pkg;

   typedef logic [21:0] xaddr_t;     // bus word address
   typedef logic [31:0] xword_t;     // bus data word

   // arbiter states
   typedef enum logic [1:0]
   {
      bus_idle,
      bus_req,
      bus_wait,
      bus_slave
   } bus_state_t;

   // dram is everything below this
   localparam xaddr_t DRAM_TOP  = 22'o17000000;

   // disk controller, eight word block
   localparam xaddr_t DISK_BASE = 22'o17377770;

   // i/o board, four word block
   localparam xaddr_t IO_BASE   = 22'o17772000;

   localparam logic [4:0] TIMEOUT_LIMIT = 5'd31;  // undecoded request ends here

endpackage
